// ==== common/axi_pkg.sv ====
package axi_pkg;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [1:0] BURST_INCR  = 2'b01;
    // Four bytes per beat
    localparam logic [2:0] SIZE_WORD   = 3'd2;

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  id;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_ar_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  id;
        logic [7:0]  len;
        logic [2:0]  size;
        logic [1:0]  burst;
    } axi_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
        logic        last;
        logic [3:0]  id;
    } axi_r_t;

    typedef struct packed {
        logic [1:0] resp;
        logic [3:0] id;
    } axi_b_t;

    // Everything a master drives
    typedef struct packed {
        axi_ar_t ar;
        logic    arvalid;
        axi_aw_t aw;
        logic    awvalid;
        axi_w_t  w;
        logic    wvalid;
        logic    rready;
        logic    bready;
    } axi_req_t;

    // Everything a slave drives
    typedef struct packed {
        logic   arready;
        logic   awready;
        logic   wready;
        axi_r_t r;
        logic   rvalid;
        axi_b_t b;
        logic   bvalid;
    } axi_resp_t;

endpackage

// ==== common/mem_pkg.sv ====
package mem_pkg;

    // SRAM depth in 32-bit words
    localparam int MEM_WORDS = 256;

    // Byte addresses at or above this limit are answered with SLVERR
    localparam int MEM_BYTES = MEM_WORDS * 4;

    localparam int WORD_IDX_W = $clog2(MEM_WORDS);

    // Words per instruction fetch burst
    localparam int FETCH_BEATS = 4;

    localparam logic [3:0] IFU_ID = 4'd0;
    localparam logic [3:0] LSU_ID = 4'd1;

    typedef enum logic [1:0] {
        GRANT_IDLE = 2'd0,
        GRANT_IFU  = 2'd1,
        GRANT_LSU  = 2'd2
    } grant_e;

endpackage

// ==== rtl/axi_arbiter.sv ====
`timescale 1ns/1ps

module axi_arbiter (
    input  logic                clock,
    input  logic                reset,

    input  logic                ifu_req,
    input  logic                lsu_req,

    input  axi_pkg::axi_req_t   ifu_bus,
    output axi_pkg::axi_resp_t  ifu_rsp,
    input  axi_pkg::axi_req_t   lsu_bus,
    output axi_pkg::axi_resp_t  lsu_rsp,

    output axi_pkg::axi_req_t   mem_bus,
    input  axi_pkg::axi_resp_t  mem_rsp
);

    import axi_pkg::*;
    import mem_pkg::*;

    localparam axi_req_t  REQ_NONE = '0;
    localparam axi_resp_t RSP_NONE = '0;

    grant_e grant;
    logic   xfer_done;

    // A transaction ends on the last read beat or the write response,
    // and only when the master actually takes it
    assign xfer_done = (mem_rsp.rvalid && mem_bus.rready && mem_rsp.r.last)
                    || (mem_rsp.bvalid && mem_bus.bready);

    always_ff @(posedge clock) begin
        if (reset) begin
            grant <= GRANT_IDLE;
        end else begin
            case (grant)
                GRANT_IDLE: begin
                    // LSU wins when both ask in the same cycle
                    if (lsu_req) begin
                        grant <= GRANT_LSU;
                    end else if (ifu_req) begin
                        grant <= GRANT_IFU;
                    end
                end
                GRANT_IFU: begin
                    if (xfer_done) begin
                        grant <= lsu_req ? GRANT_LSU : GRANT_IDLE;
                    end
                end
                GRANT_LSU: begin
                    if (xfer_done) begin
                        grant <= ifu_req ? GRANT_IFU : GRANT_IDLE;
                    end
                end
                default: begin
                    grant <= GRANT_IDLE;
                end
            endcase
        end
    end

    // The ungranted side sees a quiet bus in both directions
    always_comb begin
        mem_bus = REQ_NONE;
        ifu_rsp = RSP_NONE;
        lsu_rsp = RSP_NONE;
        case (grant)
            GRANT_IFU: begin
                mem_bus = ifu_bus;
                ifu_rsp = mem_rsp;
            end
            GRANT_LSU: begin
                mem_bus = lsu_bus;
                lsu_rsp = mem_rsp;
            end
            default: begin
                mem_bus = REQ_NONE;
            end
        endcase
    end

endmodule

// ==== ifu/ifu_fetch.sv ====
`timescale 1ns/1ps

module ifu_fetch (
    input  logic                clock,
    input  logic                reset,

    input  logic                fetch_start,
    input  logic [31:0]         fetch_pc,

    output axi_pkg::axi_req_t   ifu_bus,
    input  axi_pkg::axi_resp_t  ifu_rsp,

    output logic                ifu_req,
    output logic                fetch_busy,
    output logic                inst_valid,
    output logic [31:0]         inst,
    output logic                inst_err,
    output logic                inst_last
);

    import axi_pkg::*;
    import mem_pkg::*;

    // Clears the low address bits so a burst starts on its own boundary
    localparam logic [31:0] ALIGN_MASK = ~(32'(FETCH_BEATS * 4) - 32'd1);

    logic        busy;
    logic        arvalid;
    logic [31:0] base_addr;

    always_ff @(posedge clock) begin
        if (reset) begin
            busy    <= 1'b0;
            arvalid <= 1'b0;
        end else if (!busy && fetch_start) begin
            busy    <= 1'b1;
            arvalid <= 1'b1;
        end else begin
            if (arvalid && ifu_rsp.arready) begin
                arvalid <= 1'b0;
            end
            if (inst_last) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!busy && fetch_start) begin
            base_addr <= fetch_pc & ALIGN_MASK;
        end
    end

    always_comb begin
        ifu_bus          = '0;
        ifu_bus.ar.addr  = base_addr;
        ifu_bus.ar.id    = IFU_ID;
        ifu_bus.ar.len   = 8'(FETCH_BEATS - 1);
        ifu_bus.ar.size  = SIZE_WORD;
        ifu_bus.ar.burst = BURST_INCR;
        ifu_bus.arvalid  = arvalid;
        ifu_bus.rready   = busy;
    end

    // Every beat is taken as it arrives, so it leaves in the same cycle
    assign inst_valid = ifu_rsp.rvalid && ifu_bus.rready;
    assign inst       = ifu_rsp.r.data;
    assign inst_err   = inst_valid && (ifu_rsp.r.resp != RESP_OKAY);
    assign inst_last  = inst_valid && ifu_rsp.r.last;

    assign ifu_req    = busy;
    assign fetch_busy = busy;

endmodule

// ==== lsu/lsu_access.sv ====
`timescale 1ns/1ps

module lsu_access (
    input  logic                clock,
    input  logic                reset,

    input  logic                lsu_start,
    input  logic                lsu_write,
    input  logic [31:0]         lsu_addr,
    input  logic [31:0]         lsu_wdata,
    input  logic [3:0]          lsu_wstrb,

    output axi_pkg::axi_req_t   lsu_bus,
    input  axi_pkg::axi_resp_t  lsu_rsp,

    output logic                lsu_req,
    output logic                lsu_busy,
    output logic                lsu_done,
    output logic [31:0]         lsu_rdata,
    output logic                lsu_err
);

    import axi_pkg::*;
    import mem_pkg::*;

    logic        busy;
    logic        arvalid;
    logic        awvalid;
    logic        wvalid;
    logic        is_write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;

    always_ff @(posedge clock) begin
        if (reset) begin
            busy    <= 1'b0;
            arvalid <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end else if (!busy && lsu_start) begin
            busy    <= 1'b1;
            arvalid <= !lsu_write;
            awvalid <= lsu_write;
            wvalid  <= lsu_write;
        end else begin
            // Address and data of a store may be taken in different cycles
            if (arvalid && lsu_rsp.arready) begin
                arvalid <= 1'b0;
            end
            if (awvalid && lsu_rsp.awready) begin
                awvalid <= 1'b0;
            end
            if (wvalid && lsu_rsp.wready) begin
                wvalid <= 1'b0;
            end
            if (lsu_done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!busy && lsu_start) begin
            is_write <= lsu_write;
            addr     <= lsu_addr;
            wdata    <= lsu_wdata;
            wstrb    <= lsu_wstrb;
        end
    end

    always_comb begin
        lsu_bus          = '0;
        lsu_bus.ar.addr  = addr;
        lsu_bus.ar.id    = LSU_ID;
        lsu_bus.ar.size  = SIZE_WORD;
        lsu_bus.ar.burst = BURST_INCR;
        lsu_bus.arvalid  = arvalid;
        lsu_bus.aw.addr  = addr;
        lsu_bus.aw.id    = LSU_ID;
        lsu_bus.aw.size  = SIZE_WORD;
        lsu_bus.aw.burst = BURST_INCR;
        lsu_bus.awvalid  = awvalid;
        lsu_bus.w.data   = wdata;
        lsu_bus.w.strb   = wstrb;
        lsu_bus.w.last   = 1'b1;
        lsu_bus.wvalid   = wvalid;
        lsu_bus.rready   = busy && !is_write;
        lsu_bus.bready   = busy && is_write;
    end

    assign lsu_done = (lsu_rsp.rvalid && lsu_bus.rready) || (lsu_rsp.bvalid && lsu_bus.bready);

    // Data and error are meaningful in the cycle where lsu_done is high
    assign lsu_rdata = lsu_rsp.r.data;
    assign lsu_err   = lsu_done
                    && ((is_write ? lsu_rsp.b.resp : lsu_rsp.r.resp) != RESP_OKAY);

    assign lsu_req  = busy;
    assign lsu_busy = busy;

endmodule

// ==== rtl/axi_sram.sv ====
`timescale 1ns/1ps

module axi_sram (
    input  logic                clock,
    input  logic                reset,

    input  axi_pkg::axi_req_t   mem_bus,
    output axi_pkg::axi_resp_t  mem_rsp
);

    import axi_pkg::*;
    import mem_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_READ,
        S_WRITE,
        S_RESP
    } state_e;

    state_e      state;
    logic [31:0] mem [MEM_WORDS];

    logic        arready;
    logic        awready;
    logic        wready;
    logic        rvalid;
    logic        bvalid;
    logic        aw_got;
    logic        w_got;

    logic [31:0] raddr;
    logic [7:0]  beats_left;
    logic [3:0]  rid;
    logic [31:0] waddr;
    logic [3:0]  bid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;

    logic        ar_hs;
    logic        aw_hs;
    logic        w_hs;
    logic        r_hs;
    logic        b_hs;
    logic        rd_ok;
    logic        wr_ok;

    assign ar_hs = mem_bus.arvalid && arready;
    assign aw_hs = mem_bus.awvalid && awready;
    assign w_hs  = mem_bus.wvalid && wready;
    assign r_hs  = rvalid && mem_bus.rready;
    assign b_hs  = bvalid && mem_bus.bready;

    assign rd_ok = raddr < 32'(MEM_BYTES);
    assign wr_ok = waddr < 32'(MEM_BYTES);

    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= S_IDLE;
            arready <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            rvalid  <= 1'b0;
            bvalid  <= 1'b0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    // A pending read goes first
                    if (ar_hs) begin
                        arready <= 1'b0;
                        rvalid  <= 1'b1;
                        state   <= S_READ;
                    end else if (mem_bus.arvalid) begin
                        arready <= 1'b1;
                    end else if (mem_bus.awvalid || mem_bus.wvalid) begin
                        awready <= mem_bus.awvalid;
                        wready  <= mem_bus.wvalid;
                        state   <= S_WRITE;
                    end
                end
                S_READ: begin
                    if (r_hs && beats_left == 8'd0) begin
                        rvalid <= 1'b0;
                        state  <= S_IDLE;
                    end
                end
                S_WRITE: begin
                    if (aw_hs) begin
                        awready <= 1'b0;
                        aw_got  <= 1'b1;
                    end else if (!aw_got && mem_bus.awvalid) begin
                        awready <= 1'b1;
                    end
                    if (w_hs) begin
                        wready <= 1'b0;
                        w_got  <= 1'b1;
                    end else if (!w_got && mem_bus.wvalid) begin
                        wready <= 1'b1;
                    end
                    if ((aw_got || aw_hs) && (w_got || w_hs)) begin
                        aw_got <= 1'b0;
                        w_got  <= 1'b0;
                        bvalid <= 1'b1;
                        state  <= S_RESP;
                    end
                end
                S_RESP: begin
                    if (b_hs) begin
                        bvalid <= 1'b0;
                        state  <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Burst address and beat count, loaded on the ar handshake
    always_ff @(posedge clock) begin
        if (ar_hs) begin
            raddr      <= mem_bus.ar.addr;
            beats_left <= mem_bus.ar.len;
            rid        <= mem_bus.ar.id;
        end else if (r_hs) begin
            raddr      <= raddr + 32'd4;
            beats_left <= beats_left - 8'd1;
        end
        if (aw_hs) begin
            waddr <= mem_bus.aw.addr;
            bid   <= mem_bus.aw.id;
        end
        if (w_hs) begin
            wdata <= mem_bus.w.data;
            wstrb <= mem_bus.w.strb;
        end
    end

    // The array takes the store when its response is accepted
    always_ff @(posedge clock) begin
        if (b_hs && wr_ok) begin
            for (int i = 0; i < 4; i++) begin
                if (wstrb[i]) begin
                    mem[waddr[WORD_IDX_W+1:2]][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    always_comb begin
        mem_rsp         = '0;
        mem_rsp.arready = arready;
        mem_rsp.awready = awready;
        mem_rsp.wready  = wready;
        mem_rsp.rvalid  = rvalid;
        mem_rsp.r.data  = rd_ok ? mem[raddr[WORD_IDX_W+1:2]] : 32'd0;
        mem_rsp.r.resp  = rd_ok ? RESP_OKAY : RESP_SLVERR;
        mem_rsp.r.last  = (beats_left == 8'd0);
        mem_rsp.r.id    = rid;
        mem_rsp.bvalid  = bvalid;
        mem_rsp.b.resp  = wr_ok ? RESP_OKAY : RESP_SLVERR;
        mem_rsp.b.id    = bid;
    end

endmodule

// ==== rtl/mem_subsystem_top.sv ====
`timescale 1ns/1ps

module mem_subsystem_top (
    input  logic        clock,
    input  logic        reset,

    input  logic        fetch_start,
    input  logic [31:0] fetch_pc,
    output logic        inst_valid,
    output logic [31:0] inst,
    output logic        inst_err,
    output logic        inst_last,
    output logic        fetch_busy,

    input  logic        lsu_start,
    input  logic        lsu_write,
    input  logic [31:0] lsu_addr,
    input  logic [31:0] lsu_wdata,
    input  logic [3:0]  lsu_wstrb,
    output logic        lsu_done,
    output logic [31:0] lsu_rdata,
    output logic        lsu_err,
    output logic        lsu_busy
);

    import axi_pkg::*;

    axi_req_t  ifu_bus;
    axi_resp_t ifu_rsp;
    axi_req_t  lsu_bus;
    axi_resp_t lsu_rsp;
    axi_req_t  mem_bus;
    axi_resp_t mem_rsp;
    logic      ifu_req;
    logic      lsu_req;

    ifu_fetch ifu0 (
        .clock       (clock),
        .reset       (reset),
        .fetch_start (fetch_start),
        .fetch_pc    (fetch_pc),
        .ifu_bus     (ifu_bus),
        .ifu_rsp     (ifu_rsp),
        .ifu_req     (ifu_req),
        .fetch_busy  (fetch_busy),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .inst_err    (inst_err),
        .inst_last   (inst_last)
    );

    lsu_access lsu0 (
        .clock     (clock),
        .reset     (reset),
        .lsu_start (lsu_start),
        .lsu_write (lsu_write),
        .lsu_addr  (lsu_addr),
        .lsu_wdata (lsu_wdata),
        .lsu_wstrb (lsu_wstrb),
        .lsu_bus   (lsu_bus),
        .lsu_rsp   (lsu_rsp),
        .lsu_req   (lsu_req),
        .lsu_busy  (lsu_busy),
        .lsu_done  (lsu_done),
        .lsu_rdata (lsu_rdata),
        .lsu_err   (lsu_err)
    );

    axi_arbiter arb0 (
        .clock   (clock),
        .reset   (reset),
        .ifu_req (ifu_req),
        .lsu_req (lsu_req),
        .ifu_bus (ifu_bus),
        .ifu_rsp (ifu_rsp),
        .lsu_bus (lsu_bus),
        .lsu_rsp (lsu_rsp),
        .mem_bus (mem_bus),
        .mem_rsp (mem_rsp)
    );

    axi_sram sram0 (
        .clock   (clock),
        .reset   (reset),
        .mem_bus (mem_bus),
        .mem_rsp (mem_rsp)
    );

endmodule

// ==== test/axi_arbiter_checker.sv ====
`timescale 1ns/1ps

module axi_arbiter_checker (
    input logic               clock,
    input logic               reset,
    input mem_pkg::grant_e    grant,
    input axi_pkg::axi_req_t  ifu_bus,
    input axi_pkg::axi_resp_t ifu_rsp,
    input axi_pkg::axi_req_t  lsu_bus,
    input axi_pkg::axi_resp_t lsu_rsp,
    input axi_pkg::axi_req_t  mem_bus
);

    import axi_pkg::*;
    import mem_pkg::*;

    // Number of assertion failures seen so far
    int fail_count = 0;

    // Read data and write responses reach at most one master in a cycle
    one_responder: assert property (@(posedge clock) disable iff (reset)
        !((ifu_rsp.rvalid || ifu_rsp.bvalid) && (lsu_rsp.rvalid || lsu_rsp.bvalid)))
        else begin
            fail_count++;
            $error("rvalid or bvalid seen by both masters");
        end

    idle_quiet: assert property (@(posedge clock) disable iff (reset)
        (grant == GRANT_IDLE) |-> (!mem_bus.arvalid && !mem_bus.awvalid))
        else begin
            fail_count++;
            $error("address valid reached the SRAM with no grant");
        end

    // A granted master keeps its read request up until the SRAM takes it
    ifu_ar_hold: assert property (@(posedge clock) disable iff (reset)
        (grant == GRANT_IFU && ifu_bus.arvalid && !ifu_rsp.arready) |=> ifu_bus.arvalid)
        else begin
            fail_count++;
            $error("fetch arvalid dropped before arready");
        end

    lsu_ar_hold: assert property (@(posedge clock) disable iff (reset)
        (grant == GRANT_LSU && lsu_bus.arvalid && !lsu_rsp.arready) |=> lsu_bus.arvalid)
        else begin
            fail_count++;
            $error("load arvalid dropped before arready");
        end

endmodule

bind axi_arbiter axi_arbiter_checker chk0 (
    .clock   (clock),
    .reset   (reset),
    .grant   (grant),
    .ifu_bus (ifu_bus),
    .ifu_rsp (ifu_rsp),
    .lsu_bus (lsu_bus),
    .lsu_rsp (lsu_rsp),
    .mem_bus (mem_bus)
);

// ==== test/mem_subsystem_tb.sv ====
`timescale 1ns/1ps

module mem_subsystem_tb;

    import mem_pkg::*;

    logic        clock;
    logic        reset;
    logic        fetch_start;
    logic [31:0] fetch_pc;
    logic        inst_valid;
    logic [31:0] inst;
    logic        inst_err;
    logic        inst_last;
    logic        fetch_busy;
    logic        lsu_start;
    logic        lsu_write;
    logic [31:0] lsu_addr;
    logic [31:0] lsu_wdata;
    logic [3:0]  lsu_wstrb;
    logic        lsu_done;
    logic [31:0] lsu_rdata;
    logic        lsu_err;
    logic        lsu_busy;

    logic [31:0] model [MEM_WORDS];
    int          seed;
    int          cycle;

    logic [31:0] lsu_data_q[$];
    logic        lsu_err_q[$];
    int          lsu_cyc_q[$];
    logic [31:0] inst_q[$];
    logic        inst_err_q[$];
    logic        inst_last_q[$];
    int          inst_cyc_q[$];

    mem_subsystem_top dut0 (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    // Outputs are settled by the falling edge
    always @(negedge clock) begin
        if (lsu_done) begin
            lsu_data_q.push_back(lsu_rdata);
            lsu_err_q.push_back(lsu_err);
            lsu_cyc_q.push_back(cycle);
        end
        if (inst_valid) begin
            inst_q.push_back(inst);
            inst_err_q.push_back(inst_err);
            inst_last_q.push_back(inst_last);
            inst_cyc_q.push_back(cycle);
        end
    end

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic next_drive_slot();
        @(posedge clock);
        #2;
    endtask

    task automatic clear_results();
        lsu_data_q.delete();
        lsu_err_q.delete();
        lsu_cyc_q.delete();
        inst_q.delete();
        inst_err_q.delete();
        inst_last_q.delete();
        inst_cyc_q.delete();
    endtask

    // Both raise a start pulse in the current slot; end_pulses drops it a cycle later
    task automatic set_lsu(input logic write, input logic [31:0] addr,
                           input logic [31:0] data, input logic [3:0] strb);
        lsu_start = 1'b1;
        lsu_write = write;
        lsu_addr  = addr;
        lsu_wdata = data;
        lsu_wstrb = strb;
    endtask

    task automatic set_fetch(input logic [31:0] pc);
        fetch_start = 1'b1;
        fetch_pc    = pc;
    endtask

    task automatic end_pulses();
        next_drive_slot();
        lsu_start   = 1'b0;
        fetch_start = 1'b0;
    endtask

    task automatic wait_lsu(input int count);
        int waited;
        waited = 0;
        while (lsu_data_q.size() < count && waited < 200) begin
            @(posedge clock);
            waited++;
        end
        if (lsu_data_q.size() < count) begin
            $display("Timed out: lsu_done never came from the load/store unit");
            abort_run();
        end
    endtask

    task automatic wait_insts(input int count);
        int waited;
        waited = 0;
        while (inst_q.size() < count && waited < 200) begin
            @(posedge clock);
            waited++;
        end
        if (inst_q.size() < count) begin
            $display("Timed out: not all inst_valid beats of the fetch burst came");
            abort_run();
        end
    endtask

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        if (addr >= MEM_BYTES) begin
            return 32'd0;
        end
        return model[addr[WORD_IDX_W+1:2]];
    endfunction

    task automatic store_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        logic [WORD_IDX_W-1:0] idx;
        idx = addr[WORD_IDX_W+1:2];
        clear_results();
        next_drive_slot();
        set_lsu(1'b1, addr, data, strb);
        end_pulses();
        check_flag("lsu_busy", lsu_busy, 1'b1);
        wait_lsu(1);
        check_flag("lsu_err", lsu_err_q[0], addr >= MEM_BYTES);
        if (addr < MEM_BYTES) begin
            for (int i = 0; i < 4; i++) begin
                if (strb[i]) begin
                    model[idx][8*i +: 8] = data[8*i +: 8];
                end
            end
        end
    endtask

    task automatic load_word(input logic [31:0] addr);
        clear_results();
        next_drive_slot();
        set_lsu(1'b0, addr, 32'd0, 4'd0);
        end_pulses();
        check_flag("lsu_busy", lsu_busy, 1'b1);
        wait_lsu(1);
        check_flag("lsu_err", lsu_err_q[0], addr >= MEM_BYTES);
        check_word("lsu_rdata", lsu_data_q[0], expected_word(addr));
    endtask

    task automatic check_burst(input logic [31:0] pc);
        logic [31:0] base;
        logic [31:0] addr;
        base = pc & ~32'h0000_000f;
        wait_insts(FETCH_BEATS);
        for (int b = 0; b < FETCH_BEATS; b++) begin
            addr = base + 32'(4 * b);
            check_word("inst", inst_q[b], expected_word(addr));
            check_flag("inst_err", inst_err_q[b], addr >= MEM_BYTES);
            check_flag("inst_last", inst_last_q[b], b == FETCH_BEATS - 1);
        end
    endtask

    task automatic fetch_burst(input logic [31:0] pc);
        clear_results();
        next_drive_slot();
        set_fetch(pc);
        end_pulses();
        check_flag("fetch_busy", fetch_busy, 1'b1);
        check_burst(pc);
    endtask

    task automatic test_store_load();
        logic [31:0] addrs [5];
        addrs = '{32'h000, 32'h00c, 32'h044, 32'h190, 32'h3fc};
        foreach (addrs[i]) begin
            store_word(addrs[i], $random(seed), 4'hf);
        end
        foreach (addrs[i]) begin
            load_word(addrs[i]);
        end
    endtask

    task automatic test_byte_strobes();
        store_word(32'h190, $random(seed), 4'b0101);
        load_word(32'h190);
        store_word(32'h00c, $random(seed), 4'b1000);
        load_word(32'h00c);
    endtask

    task automatic test_fetch();
        for (int i = 16; i < 32; i++) begin
            store_word(32'(4 * i), $random(seed), 4'hf);
        end
        fetch_burst(32'h0000_0056);
    endtask

    task automatic test_contention();
        clear_results();
        next_drive_slot();
        set_lsu(1'b0, 32'h00c, 32'd0, 4'd0);
        set_fetch(32'h0000_0064);
        end_pulses();
        wait_lsu(1);
        check_word("lsu_rdata", lsu_data_q[0], expected_word(32'h00c));
        check_burst(32'h0000_0064);
        if (lsu_cyc_q[0] >= inst_cyc_q[0]) begin
            $display("Load/store unit did not finish before the first fetch beat");
            abort_run();
        end
        // A fetch arriving while a load is already on the bus
        clear_results();
        next_drive_slot();
        set_lsu(1'b0, 32'h044, 32'd0, 4'd0);
        end_pulses();
        set_fetch(32'h0000_0044);
        end_pulses();
        wait_lsu(1);
        check_word("lsu_rdata", lsu_data_q[0], expected_word(32'h044));
        check_burst(32'h0000_0044);
    endtask

    task automatic test_out_of_range();
        load_word(32'h400);
        load_word(32'h7f8);
        // Word 0 shares the low address bits with 0x400
        store_word(32'h400, $random(seed), 4'hf);
        load_word(32'h000);
        fetch_burst(32'h0000_0404);
    endtask

    initial begin
        seed        = 32'h48e4_b52f;
        cycle       = 0;
        reset       = 1'b1;
        fetch_start = 1'b0;
        fetch_pc    = 32'd0;
        lsu_start   = 1'b0;
        lsu_write   = 1'b0;
        lsu_addr    = 32'd0;
        lsu_wdata   = 32'd0;
        lsu_wstrb   = 4'd0;
        repeat (5) @(posedge clock);
        #2;
        reset = 1'b0;
        @(negedge clock);
        check_flag("fetch_busy", fetch_busy, 1'b0);
        check_flag("lsu_busy", lsu_busy, 1'b0);
        check_flag("inst_valid", inst_valid, 1'b0);
        check_flag("lsu_done", lsu_done, 1'b0);

        test_store_load();
        test_byte_strobes();
        test_fetch();
        test_contention();
        test_out_of_range();

        if (dut0.arb0.chk0.fail_count == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("Arbiter assertions failed during the run");
            abort_run();
        end
    end

endmodule

// ==== vlog.f ====
common/axi_pkg.sv
common/mem_pkg.sv
rtl/axi_arbiter.sv
ifu/ifu_fetch.sv
lsu/lsu_access.sv
rtl/axi_sram.sv
rtl/mem_subsystem_top.sv
test/axi_arbiter_checker.sv
test/mem_subsystem_tb.sv

// ==== Makefile ====
SRCS := $(wildcard common/*.sv rtl/*.sv ifu/*.sv lsu/*.sv test/*.sv)

all: run

obj_dir/Vmem_subsystem_tb: vlog.f $(SRCS)
	verilator --binary --timing --assert --top-module mem_subsystem_tb -f vlog.f -o Vmem_subsystem_tb

run: obj_dir/Vmem_subsystem_tb
	obj_dir/Vmem_subsystem_tb | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
